/* verilog/link_settings.svh */
// ******************************
// link settings
// beat width, lane delay, frame geometry and LFSR seed
// ******************************

`ifndef LINK_SETTINGS_SVH
`define LINK_SETTINGS_SVH

// octets carried in one beat
`define LINK_OCTETS_PER_BEAT 8

// lane transport delay in cycles
`define LINK_LANE_DELAY 2

`define LINK_OCTETS_PER_FRAME 3
`define LINK_FRAMES_PER_MULTIFRAME 8
`define LINK_SYSREF_HALF_PERIOD (`LINK_OCTETS_PER_FRAME * `LINK_FRAMES_PER_MULTIFRAME)

`define LINK_LFSR_SEED 16'hACE1

`endif

/* verilog/lane_pkg.sv */
// ******************************
// lane types
// octets, beats, flags and counters of the lane
// ******************************

`include "link_settings.svh"

package lane_pkg;

  typedef logic [7:0] octet_t;

  // octet 0 sits in the low byte
  typedef logic [`LINK_OCTETS_PER_BEAT*8-1:0] beat_t;

  // one control-character flag per octet
  typedef logic [`LINK_OCTETS_PER_BEAT-1:0] charisk_t;

  typedef logic [5:0] beat_count_t;
  typedef logic [15:0] char_count_t;
  typedef logic [6:0] percent_t;
  typedef logic [15:0] lfsr_t;

endpackage

/* verilog/ctrl_char_pkg.sv */
// ******************************
// control characters
// alignment character codes of the link
// ******************************

package ctrl_char_pkg;

  typedef logic [7:0] ctrl_char_t;

  // /F/ frame alignment character
  localparam ctrl_char_t CHAR_FRAME_ALIGN = 8'hFC;

  // /A/ multiframe alignment character
  localparam ctrl_char_t CHAR_MULTIFRAME_ALIGN = 8'h7C;

endpackage

/* verilog/pattern_gen.sv */
// ******************************
// pattern generator
// counter-pattern beats with a valid level
// ******************************

`timescale 1ns/1ps

`include "link_settings.svh"

module pattern_gen (
  input  logic            clk,
  input  logic            reset,
  input  logic            enable,
  output lane_pkg::beat_t gen_beat,
  output logic            gen_valid
);

  lane_pkg::beat_count_t count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      gen_valid <= 1'b0;
    end else begin
      gen_valid <= enable;
      if (enable) begin
        count <= count + 6'd1;
      end
    end
  end

  // each octet is counter then octet index
  always_ff @(posedge clk) begin
    if (enable) begin
      for (int i = 0; i < `LINK_OCTETS_PER_BEAT; i++) begin
        gen_beat[i*8 +: 8] <= {count, 2'(i)};
      end
    end
  end

endmodule

/* verilog/lane_delay.sv */
// ******************************
// lane delay
// fixed transport delay for beat and valid
// ******************************

`timescale 1ns/1ps

`include "link_settings.svh"

module lane_delay (
  input  logic            clk,
  input  logic            reset,
  input  lane_pkg::beat_t in_beat,
  input  logic            in_valid,
  output lane_pkg::beat_t out_beat,
  output logic            out_valid
);

  localparam int DEPTH = `LINK_LANE_DELAY;

  lane_pkg::beat_t  beat_q [DEPTH];
  logic [DEPTH-1:0] valid_q;

  always_ff @(posedge clk) begin
    beat_q[0] <= in_beat;
    for (int i = 1; i < DEPTH; i++) begin
      beat_q[i] <= beat_q[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= in_valid;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  assign out_beat = beat_q[DEPTH-1];
  assign out_valid = valid_q[DEPTH-1];

endmodule

/* verilog/align_err_inject.sv */
// ******************************
// alignment error injector
// replaces beats by /F/ or /A/ at a set rate
// ******************************

`timescale 1ns/1ps

`include "link_settings.svh"

module align_err_inject (
  input  logic               clk,
  input  logic               reset,
  input  lane_pkg::beat_t    in_beat,
  input  logic               in_valid,
  input  logic               err_frame,
  input  logic               err_multiframe,
  input  lane_pkg::percent_t err_percent,
  output lane_pkg::beat_t    phy_data,
  output lane_pkg::charisk_t phy_charisk,
  output logic               phy_valid
);

  lane_pkg::lfsr_t            lfsr;
  logic                       feedback;
  lane_pkg::percent_t         roll;
  logic                       hit;
  ctrl_char_pkg::ctrl_char_t  fill;

  // ******************************
  // x^16+x^14+x^13+x^11+1, shifting right
  assign feedback = lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5];

  always_ff @(posedge clk) begin
    if (reset) begin
      lfsr <= `LINK_LFSR_SEED;
    end else begin
      lfsr <= {feedback, lfsr[15:1]};
    end
  end

  // low 7 bits folded into 0..99
  assign roll = (lfsr[6:0] >= 7'd100) ? lfsr[6:0] - 7'd100 : lfsr[6:0];
  assign hit = in_valid & (err_frame | err_multiframe) & (roll < err_percent);

  // multiframe wins when both are requested
  assign fill = err_multiframe ? ctrl_char_pkg::CHAR_MULTIFRAME_ALIGN
                               : ctrl_char_pkg::CHAR_FRAME_ALIGN;

  // ******************************
  always_ff @(posedge clk) begin
    if (reset) begin
      phy_valid <= 1'b0;
      phy_charisk <= '0;
    end else begin
      phy_valid <= in_valid;
      phy_charisk <= hit ? '1 : '0;
    end
  end

  always_ff @(posedge clk) begin
    phy_data <= hit ? {`LINK_OCTETS_PER_BEAT{fill}} : in_beat;
  end

endmodule

/* verilog/sysref_gen.sv */
// ******************************
// sysref generator
// toggles at the multiframe rate
// ******************************

`timescale 1ns/1ps

`include "link_settings.svh"

module sysref_gen (
  input  logic clk,
  input  logic reset,
  output logic sysref
);

  localparam int HALF = `LINK_SYSREF_HALF_PERIOD;
  localparam int CNT_W = $clog2(HALF);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      sysref <= 1'b0;
    end else if (count == CNT_W'(HALF - 1)) begin
      count <= '0;
      sysref <= ~sysref;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

/* verilog/pattern_check.sv */
// ******************************
// pattern checker
// compares received beats with the counter pattern
// ******************************

`timescale 1ns/1ps

`include "link_settings.svh"

module pattern_check (
  input  logic                  clk,
  input  logic                  reset,
  input  lane_pkg::beat_t       phy_data,
  input  lane_pkg::charisk_t    phy_charisk,
  input  logic                  phy_valid,
  output logic                  mismatch,
  output lane_pkg::char_count_t align_char_count
);

  lane_pkg::beat_count_t exp_count;
  lane_pkg::beat_t       expected;
  logic                  is_char;

  always_comb begin
    for (int i = 0; i < `LINK_OCTETS_PER_BEAT; i++) begin
      expected[i*8 +: 8] = {exp_count, 2'(i)};
    end
  end

  assign is_char = |phy_charisk;

  // counter steps on every valid beat so it stays locked
  // across replaced beats
  always_ff @(posedge clk) begin
    if (reset) begin
      exp_count <= '0;
      mismatch <= 1'b0;
      align_char_count <= '0;
    end else if (phy_valid) begin
      exp_count <= exp_count + 6'd1;
      if (is_char) begin
        align_char_count <= align_char_count + 16'd1;
      end else if (phy_data != expected) begin
        // sticky until reset
        mismatch <= 1'b1;
      end
    end
  end

endmodule

/* verilog/link_loopback_top.sv */
// ******************************
// link loopback top
// generator, lane delay, injector, checker and sysref
// ******************************

`timescale 1ns/1ps

module link_loopback_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  enable,
  input  logic                  err_frame,
  input  logic                  err_multiframe,
  input  lane_pkg::percent_t    err_percent,
  output lane_pkg::beat_t       phy_data,
  output lane_pkg::charisk_t    phy_charisk,
  output logic                  phy_valid,
  output logic                  sysref,
  output logic                  mismatch,
  output lane_pkg::char_count_t align_char_count
);

  lane_pkg::beat_t gen_beat;
  logic            gen_valid;
  lane_pkg::beat_t dly_beat;
  logic            dly_valid;

  // ******************************
  // transmit side and lane
  pattern_gen i_gen (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .gen_beat  (gen_beat),
    .gen_valid (gen_valid)
  );

  lane_delay i_delay (
    .clk       (clk),
    .reset     (reset),
    .in_beat   (gen_beat),
    .in_valid  (gen_valid),
    .out_beat  (dly_beat),
    .out_valid (dly_valid)
  );

  align_err_inject i_inject (
    .clk            (clk),
    .reset          (reset),
    .in_beat        (dly_beat),
    .in_valid       (dly_valid),
    .err_frame      (err_frame),
    .err_multiframe (err_multiframe),
    .err_percent    (err_percent),
    .phy_data       (phy_data),
    .phy_charisk    (phy_charisk),
    .phy_valid      (phy_valid)
  );

  // ******************************
  // receive side
  pattern_check i_check (
    .clk              (clk),
    .reset            (reset),
    .phy_data         (phy_data),
    .phy_charisk      (phy_charisk),
    .phy_valid        (phy_valid),
    .mismatch         (mismatch),
    .align_char_count (align_char_count)
  );

  sysref_gen i_sysref (
    .clk    (clk),
    .reset  (reset),
    .sysref (sysref)
  );

endmodule

/* tb/link_loopback_chk.sv */
// ******************************
// link loopback checks
// assertions on the injector flags and the checker
// ******************************

`timescale 1ns/1ps

module link_loopback_chk (
  input logic               clk,
  input logic               reset,
  input lane_pkg::charisk_t phy_charisk,
  input logic               phy_valid,
  input logic               mismatch
);

  // a beat is replaced whole or not at all
  a_charisk_whole: assert property (@(posedge clk) disable iff (reset)
    (phy_charisk == '0) || (phy_charisk == '1))
    else $error("phy_charisk is neither all ones nor all zeros");

  a_charisk_idle: assert property (@(posedge clk) disable iff (reset)
    !phy_valid |-> phy_charisk == '0)
    else $error("phy_charisk set while phy_valid is low");

  // checker stays locked across alignment characters
  a_no_mismatch: assert property (@(posedge clk) disable iff (reset) !mismatch)
    else $error("pattern checker raised mismatch");

endmodule

/* tb/link_loopback_tb.sv */
// ******************************
// link loopback testbench
// reads the test table, drives the link and checks every beat
// ******************************

`timescale 1ns/1ps

`include "link_settings.svh"

module link_loopback_tb;

  // register stages from the enable sample to phy_valid
  localparam int STAGES = 1 + `LINK_LANE_DELAY + 1;
  localparam int HALF = `LINK_SYSREF_HALF_PERIOD;
  localparam logic [7:0] FRAME_CHAR = 8'hFC;
  localparam logic [7:0] MULTI_CHAR = 8'h7C;

  logic                  clk;
  logic                  reset;
  logic                  enable;
  logic                  err_frame;
  logic                  err_multiframe;
  lane_pkg::percent_t    err_percent;
  lane_pkg::beat_t       phy_data;
  lane_pkg::charisk_t    phy_charisk;
  logic                  phy_valid;
  logic                  sysref;
  logic                  mismatch;
  lane_pkg::char_count_t align_char_count;

  string test_names[$];
  int    test_beats[$];
  int    test_frame[$];
  int    test_multi[$];
  int    test_percent[$];
  string cur_name;
  int    cycle_count;
  int    cycle_limit;

  link_loopback_top DUT (.*);

  bind link_loopback_top link_loopback_chk i_chk (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // run limit, armed once the table is loaded
  initial begin
    cycle_count = 0;
    wait (cycle_limit > 0);
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        $display("timeout: the run did not end within %0d cycles", cycle_limit);
        $display("Some tests failed");
        $fatal(1, "timeout");
      end
    end
  end

  task automatic check_value(input string item, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: %s expected %h actual %h", cur_name, item, expected, actual);
      $display("Some tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // octet i is the beat count followed by the low bits of i
  function automatic lane_pkg::beat_t make_pattern(input int count);
    lane_pkg::beat_t beat;
    for (int i = 0; i < `LINK_OCTETS_PER_BEAT; i++) begin
      beat[i*8 +: 8] = {count[5:0], i[1:0]};
    end
    return beat;
  endfunction

  function automatic lane_pkg::beat_t fill_beat(input logic [7:0] code);
    return {`LINK_OCTETS_PER_BEAT{code}};
  endfunction

  // ******************************
  task automatic load_tests();
    int    fd;
    int    n;
    int    sum;
    string line;
    string name;
    int    beats;
    int    fr;
    int    mf;
    int    pct;
    sum = 0;
    fd = $fopen("tb/link_loopback_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test table tb/link_loopback_tests.txt");
      $display("Some tests failed");
      $fatal(1, "no test table");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %d %d %d %d", name, beats, fr, mf, pct);
        if (n == 5) begin
          test_names.push_back(name);
          test_beats.push_back(beats);
          test_frame.push_back(fr);
          test_multi.push_back(mf);
          test_percent.push_back(pct);
          sum += beats + 40;
        end
      end
    end
    $fclose(fd);
    cycle_limit = 2 * sum;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    enable = 1'b0;
    repeat (10) begin
      @(posedge clk);
      #1;
    end
    reset = 1'b0;
  endtask

  // one toggle per completed half period after reset falls
  task automatic check_sysref();
    cur_name = "sysref";
    apply_reset();
    for (int edge_n = 1; edge_n <= 3 * HALF + 8; edge_n++) begin
      @(posedge clk);
      #1;
      check_value($sformatf("sysref after edge %0d", edge_n), 64'((edge_n / HALF) % 2),
                  64'(sysref));
    end
  endtask

  task automatic run_test(input int idx);
    int         beats;
    int         exp_count;
    int         chars_seen;
    bit         all_hit;
    bit         no_hit;
    logic [7:0] code;
    cur_name = test_names[idx];
    beats = test_beats[idx];
    err_frame = (test_frame[idx] != 0);
    err_multiframe = (test_multi[idx] != 0);
    err_percent = 7'(test_percent[idx]);
    all_hit = (err_frame || err_multiframe) && test_percent[idx] >= 100;
    no_hit = !(err_frame || err_multiframe) || test_percent[idx] == 0;
    code = err_multiframe ? MULTI_CHAR : FRAME_CHAR;
    exp_count = 0;
    chars_seen = 0;
    apply_reset();
    enable = (beats > 0);
    for (int c = 1; c <= beats + STAGES + 2; c++) begin
      @(posedge clk);
      #1;
      enable = (c < beats);
      check_value("phy_valid", 64'(c >= STAGES && c < STAGES + beats), 64'(phy_valid));
      // the checker counts a beat one cycle after it arrives
      check_value("align_char_count", 64'(chars_seen), 64'(align_char_count));
      check_value("mismatch", 64'd0, 64'(mismatch));
      if (phy_valid) begin
        if (all_hit || (!no_hit && phy_charisk != '0)) begin
          check_value("phy_data", fill_beat(code), phy_data);
          check_value("phy_charisk", 64'hFF, 64'(phy_charisk));
          chars_seen++;
        end else begin
          check_value("phy_data", make_pattern(exp_count), phy_data);
          check_value("phy_charisk", 64'h0, 64'(phy_charisk));
        end
        exp_count++;
      end
    end
    if (all_hit) begin
      check_value("align_char_count", 64'(beats), 64'(align_char_count));
    end else if (!no_hit) begin
      // a partial rate leaves both kinds of beat on the lane
      check_value("mixed beats", 64'd1, 64'(chars_seen > 0 && chars_seen < beats));
    end
    $display("test %s: %0d beats, %0d alignment characters", cur_name, beats, chars_seen);
  endtask

  // ******************************
  initial begin
    reset = 1'b1;
    enable = 1'b0;
    err_frame = 1'b0;
    err_multiframe = 1'b0;
    err_percent = '0;
    load_tests();
    check_sysref();
    foreach (test_names[i]) begin
      run_test(i);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

/* tb/link_loopback_tests.txt */
# columns: name beats err_frame err_multiframe err_percent
# err_percent is decimal, 0 to 100
clean 40 0 0 0
frame_all 30 1 0 100
multi_all 30 0 1 100
both_all 20 1 1 100
frame_half 60 1 0 50
multi_half 60 0 1 50
clean_wrap 80 0 0 0

/* verilog.f */
+incdir+verilog
verilog/lane_pkg.sv
verilog/ctrl_char_pkg.sv
verilog/pattern_gen.sv
verilog/lane_delay.sv
verilog/align_err_inject.sv
verilog/sysref_gen.sv
verilog/pattern_check.sv
verilog/link_loopback_top.sv
tb/link_loopback_chk.sv
tb/link_loopback_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = link_loopback_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Some tests failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
